// File: Bender.yml
package:
  name: trace_buffer

sources:
  - trace_pkg.sv
  - trace_regs_pkg.sv
  - trace_capture.sv
  - trace_store.sv
  - trace_wb_regs.sv
  - trace_top.sv
  - target: test
    files:
      - tb_trace_top.sv

// File: compile.f
trace_pkg.sv
trace_regs_pkg.sv
trace_capture.sv
trace_store.sv
trace_wb_regs.sv
trace_top.sv
tb_trace_top.sv

// File: tb_trace_top.sv
`timescale 1ns/1ps

module tb_trace_top;

    // Small depth so the store wraps after a few records
    localparam int NUM_ENTRIES  = 8;
    localparam int BUS_TIMEOUT  = 20;
    localparam logic [31:0] SEED = 32'he390_a3bd;

    logic                    clk;
    logic                    rst_b;
    logic                    debug_en;
    trace_pkg::retire_rec_t  retire;
    trace_regs_pkg::wb_req_t wb_req;
    trace_regs_pkg::wb_rsp_t wb_rsp;

    // LFSR state, one step per stimulus bit
    logic [31:0]  lfsr_state;
    // Expected packets, same slot order as the store
    logic [127:0] model [NUM_ENTRIES];
    // Records the store should hold so far
    int           model_wr;

    trace_top #(.NUM_ENTRIES(NUM_ENTRIES)) dut_i (
        .clk      (clk),
        .rst_b    (rst_b),
        .debug_en (debug_en),
        .retire   (retire),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // Stimulus source
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Entry is pointer over four, dword is the low two bits
    function automatic logic [31:0] ref_dword(input int dptr);
        logic [127:0] p;
        p = model[(dptr / 4) % NUM_ENTRIES];
        return p[(dptr % 4) * 32 +: 32];
    endfunction

    //////////////////////////////
    // Failure and compare
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // Wishbone master
    //////////////////////////////

    // Request held until ack or err, then dropped
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic err);
        int n;
        n = 0;
        @(posedge clk);
        #2;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        while (!(wb_rsp.ack || wb_rsp.err)) begin
            if (n == BUS_TIMEOUT) begin
                abort_run($sformatf("no ack or err from the bus slave at offset 0x%02h", adr));
            end else begin
                @(posedge clk);
                #1;
                n++;
            end
        end
        rdat = wb_rsp.dat;
        err  = wb_rsp.err;
        #1;
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat, output logic err);
        bus_cycle(1'b0, adr, 32'h0, rdat, err);
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] wdat, output logic err);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, wdat, unused, err);
    endtask

    task automatic expect_read(input logic [7:0] adr, input logic [31:0] exp, input string name);
        logic [31:0] d;
        logic        e;
        wb_read(adr, d, e);
        check({name, "_err"}, 32'(e), 32'h0);
        check(name, d, exp);
    endtask

    task automatic expect_write(input logic [7:0] adr, input logic [31:0] wdat,
                                input string name);
        logic e;
        wb_write(adr, wdat, e);
        check({name, "_err"}, 32'(e), 32'h0);
    endtask

    // Access that the slave has to refuse
    // Zero write data would clear CONTROL and READ_PTR if it were taken
    task automatic expect_err(input logic we, input logic [7:0] adr, input string name);
        logic [31:0] d;
        logic        e;
        bus_cycle(we, adr, 32'h0, d, e);
        check({name, "_err"}, 32'(e), 32'h1);
    endtask

    //////////////////////////////
    // Retire port driver
    //////////////////////////////

    // One record per cycle, model only follows when capture is expected
    task automatic send_records(input int count, input bit stored);
        trace_pkg::retire_rec_t rec;
        logic [31:0]            r;
        for (int k = 0; k < count; k++) begin
            rec.valid = 1'b1;
            take_bits(32, r);
            rec.insn = r;
            take_bits(32, r);
            rec.address = r;
            take_bits(32, r);
            rec.tval = r;
            take_bits(7, r);
            rec.exception = r[0];
            rec.ecause    = r[5:1];
            rec.interrupt = r[6];
            @(posedge clk);
            #2;
            retire = rec;
            if (stored) begin
                // Info word on top, insn in the lowest dword
                model[model_wr % NUM_ENTRIES] = {25'b0, rec.interrupt, rec.ecause,
                    rec.exception, rec.tval, rec.address, rec.insn};
                model_wr++;
            end
        end
        @(posedge clk);
        #2;
        retire = '0;
    endtask

    // Walk READ_PTR over a range and compare DATA
    task automatic check_data(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            expect_write(trace_regs_pkg::REG_READ_PTR, 32'(i), "READ_PTR");
            expect_read(trace_regs_pkg::REG_DATA, ref_dword(i), $sformatf("DATA[%0d]", i));
        end
    endtask

    function automatic logic [31:0] exp_wr_ptr();
        return 32'((model_wr % NUM_ENTRIES) * 4);
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        clk        = 1'b0;
        rst_b      = 1'b0;
        debug_en   = 1'b1;
        retire     = '0;
        wb_req     = '0;
        lfsr_state = SEED;
        model_wr   = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_b = 1'b1;

        // Reset values
        expect_read(trace_regs_pkg::REG_STATUS, 32'h0, "STATUS");
        expect_read(trace_regs_pkg::REG_CONFIG, 32'(NUM_ENTRIES * 4), "CONFIG");
        expect_read(trace_regs_pkg::REG_WRITE_PTR, 32'h0, "WRITE_PTR");
        expect_read(trace_regs_pkg::REG_CONTROL, 32'h0, "CONTROL");

        // Capture still off
        send_records(5, 1'b0);
        expect_read(trace_regs_pkg::REG_WRITE_PTR, 32'h0, "WRITE_PTR");
        expect_read(trace_regs_pkg::REG_STATUS, 32'h0, "STATUS");

        // Capture on, five records
        expect_write(trace_regs_pkg::REG_CONTROL, 32'h1, "CONTROL");
        send_records(5, 1'b1);
        expect_read(trace_regs_pkg::REG_STATUS, 32'h1, "STATUS");
        expect_read(trace_regs_pkg::REG_WRITE_PTR, exp_wr_ptr(), "WRITE_PTR");
        check_data(0, 20);

        // Sixteen records in total, store has wrapped
        send_records(11, 1'b1);
        expect_read(trace_regs_pkg::REG_STATUS, 32'h3, "STATUS");
        expect_read(trace_regs_pkg::REG_WRITE_PTR, exp_wr_ptr(), "WRITE_PTR");
        check_data(0, NUM_ENTRIES * 4);

        // Debug mode off, bus refused and capture blocked
        @(posedge clk);
        #2;
        debug_en = 1'b0;
        expect_err(1'b0, trace_regs_pkg::REG_STATUS, "STATUS");
        expect_err(1'b1, trace_regs_pkg::REG_CONTROL, "CONTROL");
        expect_err(1'b1, trace_regs_pkg::REG_READ_PTR, "READ_PTR");
        send_records(4, 1'b0);
        @(posedge clk);
        #2;
        debug_en = 1'b1;
        expect_read(trace_regs_pkg::REG_WRITE_PTR, exp_wr_ptr(), "WRITE_PTR");
        expect_read(trace_regs_pkg::REG_CONTROL, 32'h1, "CONTROL");
        expect_read(trace_regs_pkg::REG_READ_PTR, 32'(NUM_ENTRIES * 4 - 1), "READ_PTR");

        // Unknown offset and read-only writes
        expect_err(1'b0, 8'h18, "OFFSET_18");
        expect_err(1'b1, 8'h18, "OFFSET_18");
        expect_err(1'b1, trace_regs_pkg::REG_STATUS, "STATUS");
        expect_err(1'b1, trace_regs_pkg::REG_CONFIG, "CONFIG");
        expect_err(1'b1, trace_regs_pkg::REG_WRITE_PTR, "WRITE_PTR");
        expect_err(1'b1, trace_regs_pkg::REG_DATA, "DATA");
        expect_read(trace_regs_pkg::REG_STATUS, 32'h3, "STATUS");
        expect_read(trace_regs_pkg::REG_CONFIG, 32'(NUM_ENTRIES * 4), "CONFIG");
        expect_read(trace_regs_pkg::REG_WRITE_PTR, exp_wr_ptr(), "WRITE_PTR");
        expect_read(trace_regs_pkg::REG_READ_PTR, 32'(NUM_ENTRIES * 4 - 1), "READ_PTR");
        expect_read(trace_regs_pkg::REG_CONTROL, 32'h1, "CONTROL");
        check_data(0, 4);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: trace_capture.sv
`timescale 1ns/1ps

module trace_capture (
    input  logic                     clk,
    input  logic                     rst_b,
    input  logic                     debug_en,
    input  logic                     capture_en,
    input  trace_pkg::retire_rec_t   retire,
    output trace_pkg::trace_packet_t pkt,
    output logic                     pkt_valid
);

    // Record accepted this cycle
    logic admit;
    // Packet built from the incoming record
    trace_pkg::trace_packet_t pkt_next;

    //////////////////////////////
    // Qualify
    //////////////////////////////

    // Needs a retired insn, debug mode and capture switched on
    assign admit = retire.valid && debug_en && capture_en;

    //////////////////////////////
    // Pack
    //////////////////////////////

    always_comb begin
        pkt_next.insn    = retire.insn;
        pkt_next.address = retire.address;
        pkt_next.tval    = retire.tval;
        // Info word, upper bits always zero
        pkt_next.info.reserved  = '0;
        pkt_next.info.interrupt = retire.interrupt;
        pkt_next.info.ecause    = retire.ecause;
        pkt_next.info.exception = retire.exception;
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Valid flag, one pulse per admitted record
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= admit;
        end
    end

    // Payload only loads on admit
    always_ff @(posedge clk) begin
        if (admit) begin
            pkt <= pkt_next;
        end
    end

    // No packet may come out of a cycle with debug mode off
    a_no_capture_without_debug: assert property (
        @(posedge clk) disable iff (!rst_b)
        !$past(debug_en) |-> !pkt_valid
    );

endmodule

// File: trace_pkg.sv
package trace_pkg;

    //////////////////////////////
    // Packet geometry
    //////////////////////////////

    // Dwords held in one stored packet
    localparam int PACKET_DWORDS  = 4;
    // Bits that pick a dword inside a packet
    localparam int DWORD_SEL_BITS = 2;

    //////////////////////////////
    // Retire trace record
    //////////////////////////////

    // One retired instruction as seen at the core trace port
    typedef struct packed {
        logic        valid;
        logic [31:0] insn;
        logic [31:0] address;
        logic        exception;
        logic [4:0]  ecause;
        logic        interrupt;
        logic [31:0] tval;
    } retire_rec_t;

    //////////////////////////////
    // Stored packet
    //////////////////////////////

    // Info dword, exception summary in the low bits
    typedef struct packed {
        logic [24:0] reserved;
        logic        interrupt;
        logic [4:0]  ecause;
        logic        exception;
    } trace_info_t;

    // Last member sits in the low bits, so insn is dword 0
    typedef struct packed {
        trace_info_t info;
        logic [31:0] tval;
        logic [31:0] address;
        logic [31:0] insn;
    } trace_packet_t;

endpackage

// File: trace_regs_pkg.sv
package trace_regs_pkg;

    //////////////////////////////
    // Wishbone classic bus
    //////////////////////////////

    // Master to slave, held stable until ack or err
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // Slave to master, one-cycle answer
    typedef struct packed {
        logic        ack;
        logic        err;
        logic [31:0] dat;
    } wb_rsp_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // Byte offsets of the trace registers
    typedef enum logic [7:0] {
        REG_STATUS    = 8'h00,
        REG_CONFIG    = 8'h04,
        REG_WRITE_PTR = 8'h08,
        REG_READ_PTR  = 8'h0C,
        REG_DATA      = 8'h10,
        REG_CONTROL   = 8'h14
    } reg_off_e;

    // STATUS register fields
    localparam int STATUS_VALID_BIT   = 0;
    localparam int STATUS_WRAPPED_BIT = 1;

endpackage

// File: trace_store.sv
`timescale 1ns/1ps

module trace_store #(
    parameter int  NUM_ENTRIES = 64,
    localparam int PTR_W       = $clog2(NUM_ENTRIES),
    localparam int DWORD_PTR_W = PTR_W + trace_pkg::DWORD_SEL_BITS
) (
    input  logic                     clk,
    input  logic                     rst_b,
    input  trace_pkg::trace_packet_t pkt,
    input  logic                     pkt_valid,
    input  logic [DWORD_PTR_W-1:0]   rd_dword_ptr,
    output logic [31:0]              rd_dword,
    output logic [PTR_W-1:0]         wr_ptr,
    output logic                     valid_data,
    output logic                     wrapped
);

    // Packet storage, no reset on the array
    trace_pkg::trace_packet_t mem [NUM_ENTRIES];

    // Read side split of the dword pointer
    logic [PTR_W-1:0]                    rd_entry;
    logic [trace_pkg::DWORD_SEL_BITS-1:0] rd_sel;
    // Selected packet viewed as dwords
    logic [trace_pkg::PACKET_DWORDS-1:0][31:0] rd_words;

    // Last slot before the pointer rolls over
    logic at_last;

    assign at_last = (wr_ptr == PTR_W'(NUM_ENTRIES - 1));

    //////////////////////////////
    // Write pointer and flags
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr     <= '0;
            valid_data <= 1'b0;
            wrapped    <= 1'b0;
        end else begin
            if (pkt_valid) begin
                // Sticky once anything was stored
                valid_data <= 1'b1;
                // Power-of-two depth, pointer wraps on its own
                wr_ptr     <= wr_ptr + 1'b1;
                if (at_last) begin
                    wrapped <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // Storage write
    //////////////////////////////

    // Oldest entry is overwritten, no back-pressure
    always_ff @(posedge clk) begin
        if (pkt_valid) begin
            mem[wr_ptr] <= pkt;
        end
    end

    //////////////////////////////
    // Dword read port
    //////////////////////////////

    // Upper bits give the entry, i.e. pointer divided by four
    assign rd_entry = rd_dword_ptr[DWORD_PTR_W-1:trace_pkg::DWORD_SEL_BITS];
    // Low bits pick the dword in that entry
    assign rd_sel   = rd_dword_ptr[trace_pkg::DWORD_SEL_BITS-1:0];

    assign rd_words = mem[rd_entry];
    assign rd_dword = rd_words[rd_sel];

    // A wrap can only follow at least one stored packet
    a_wrapped_implies_valid: assert property (
        @(posedge clk) disable iff (!rst_b)
        wrapped |-> valid_data
    );

endmodule

// File: trace_top.sv
`timescale 1ns/1ps

module trace_top #(
    parameter int  NUM_ENTRIES = 64,
    localparam int PTR_W       = $clog2(NUM_ENTRIES),
    localparam int DWORD_PTR_W = PTR_W + trace_pkg::DWORD_SEL_BITS
) (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    debug_en,
    input  trace_pkg::retire_rec_t  retire,
    input  trace_regs_pkg::wb_req_t wb_req,
    output trace_regs_pkg::wb_rsp_t wb_rsp
);

    //////////////////////////////
    // Internal wires
    //////////////////////////////

    // Capture to store
    trace_pkg::trace_packet_t pkt;
    logic                     pkt_valid;
    // Store to register slave
    logic [PTR_W-1:0]         wr_ptr;
    logic                     valid_data;
    logic                     wrapped;
    logic [31:0]              rd_dword;
    // Register slave back to store and capture
    logic [DWORD_PTR_W-1:0]   rd_dword_ptr;
    logic                     capture_en;

    trace_capture capture_i (
        .clk        (clk),
        .rst_b      (rst_b),
        .debug_en   (debug_en),
        .capture_en (capture_en),
        .retire     (retire),
        .pkt        (pkt),
        .pkt_valid  (pkt_valid)
    );

    trace_store #(.NUM_ENTRIES(NUM_ENTRIES)) store_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .pkt          (pkt),
        .pkt_valid    (pkt_valid),
        .rd_dword_ptr (rd_dword_ptr),
        .rd_dword     (rd_dword),
        .wr_ptr       (wr_ptr),
        .valid_data   (valid_data),
        .wrapped      (wrapped)
    );

    // Debugger side register access
    trace_wb_regs #(.NUM_ENTRIES(NUM_ENTRIES)) regs_i (
        .clk          (clk),
        .rst_b        (rst_b),
        .debug_en     (debug_en),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .wr_ptr       (wr_ptr),
        .valid_data   (valid_data),
        .wrapped      (wrapped),
        .rd_dword     (rd_dword),
        .rd_dword_ptr (rd_dword_ptr),
        .capture_en   (capture_en)
    );

endmodule

// File: trace_wb_regs.sv
`timescale 1ns/1ps

module trace_wb_regs #(
    parameter int  NUM_ENTRIES = 64,
    localparam int PTR_W       = $clog2(NUM_ENTRIES),
    localparam int DWORD_PTR_W = PTR_W + trace_pkg::DWORD_SEL_BITS
) (
    input  logic                    clk,
    input  logic                    rst_b,
    input  logic                    debug_en,
    input  trace_regs_pkg::wb_req_t wb_req,
    output trace_regs_pkg::wb_rsp_t wb_rsp,
    input  logic [PTR_W-1:0]        wr_ptr,
    input  logic                    valid_data,
    input  logic                    wrapped,
    input  logic [31:0]             rd_dword,
    output logic [DWORD_PTR_W-1:0]  rd_dword_ptr,
    output logic                    capture_en
);

    // Decoded offset
    trace_regs_pkg::reg_off_e off;
    // Request seen for the first time
    logic req_new;
    // Decode results
    logic        hit;
    logic        writable;
    logic        bad;
    logic        wr_ok;
    logic [31:0] rd_data;
    // Registered response
    logic        rsp_ack;
    logic        rsp_err;
    logic [31:0] rsp_dat;

    //////////////////////////////
    // Request detect
    //////////////////////////////

    // Skip the cycle where this access is already being answered
    assign req_new = wb_req.cyc && wb_req.stb && !(rsp_ack || rsp_err);

    assign off = trace_regs_pkg::reg_off_e'(wb_req.adr);

    //////////////////////////////
    // Decode and read mux
    //////////////////////////////

    always_comb begin
        rd_data  = '0;
        hit      = 1'b1;
        writable = 1'b0;
        case (off)
            trace_regs_pkg::REG_STATUS: begin
                rd_data[trace_regs_pkg::STATUS_VALID_BIT]   = valid_data;
                rd_data[trace_regs_pkg::STATUS_WRAPPED_BIT] = wrapped;
            end
            // Depth counted in dwords
            trace_regs_pkg::REG_CONFIG:
                rd_data = 32'(NUM_ENTRIES * trace_pkg::PACKET_DWORDS);
            // Entry index turned into a dword index
            trace_regs_pkg::REG_WRITE_PTR:
                rd_data = 32'(wr_ptr) << trace_pkg::DWORD_SEL_BITS;
            trace_regs_pkg::REG_READ_PTR: begin
                rd_data  = 32'(rd_dword_ptr);
                writable = 1'b1;
            end
            trace_regs_pkg::REG_DATA:
                rd_data = rd_dword;
            trace_regs_pkg::REG_CONTROL: begin
                rd_data  = {31'b0, capture_en};
                writable = 1'b1;
            end
            default:
                hit = 1'b0;
        endcase
    end

    // Unknown offset, read-only write or no debug mode
    assign bad   = !debug_en || !hit || (wb_req.we && !writable);
    assign wr_ok = req_new && !bad && wb_req.we;

    //////////////////////////////
    // Response and control regs
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp_ack      <= 1'b0;
            rsp_err      <= 1'b0;
            rd_dword_ptr <= '0;
            capture_en   <= 1'b0;
        end else begin
            rsp_ack <= req_new && !bad;
            rsp_err <= req_new && bad;
            // Writes land on the same edge as the ack
            if (wr_ok && off == trace_regs_pkg::REG_READ_PTR) begin
                rd_dword_ptr <= wb_req.dat[DWORD_PTR_W-1:0];
            end
            if (wr_ok && off == trace_regs_pkg::REG_CONTROL) begin
                capture_en <= wb_req.dat[0];
            end
        end
    end

    // Read data, zero on an error answer
    always_ff @(posedge clk) begin
        if (req_new) begin
            rsp_dat <= bad ? '0 : rd_data;
        end
    end

    assign wb_rsp = '{ack: rsp_ack, err: rsp_err, dat: rsp_dat};

    a_ack_err_exclusive: assert property (
        @(posedge clk) disable iff (!rst_b)
        !(wb_rsp.ack && wb_rsp.err)
    );

    // Every answer belongs to a request open one cycle earlier
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (!rst_b)
        (wb_rsp.ack || wb_rsp.err) |-> $past(wb_req.cyc && wb_req.stb)
    );

endmodule
